// File: frv_decode_settings.svh
`ifndef FRV_DECODE_SETTINGS_SVH
`define FRV_DECODE_SETTINGS_SVH

// Datapath widths
`define FRV_XLEN   32   // Instruction word and immediate width
`define FRV_REG_W  5    // Register address width

// Fixed register numbers
`define FRV_REG_ZERO 0

// Trap causes, carried in the rd field of a trapping result
`define FRV_TRAP_IACCESS 1   // Fetch access fault
`define FRV_TRAP_IOPCODE 2   // Illegal instruction

`endif

// File: frv_decode_pkg.sv
`include "frv_decode_settings.svh"

package frv_decode_pkg;

    // Major opcodes of the kept RV32I encodings
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OPIMM  = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    // One value per kept instruction
    typedef enum logic [5:0] {
        CLS_INVALID,
        CLS_ADD, CLS_SUB, CLS_AND, CLS_OR, CLS_XOR,
        CLS_SLT, CLS_SLTU, CLS_SLL, CLS_SRL, CLS_SRA,
        CLS_ADDI, CLS_ANDI, CLS_ORI, CLS_XORI, CLS_SLTI,
        CLS_SLTIU, CLS_SLLI, CLS_SRLI, CLS_SRAI,
        CLS_LUI, CLS_AUIPC,
        CLS_BEQ, CLS_BNE, CLS_BLT, CLS_BGE, CLS_BLTU, CLS_BGEU,
        CLS_JAL, CLS_JALR, CLS_ECALL, CLS_EBREAK,
        CLS_LB, CLS_LBU, CLS_LH, CLS_LHU, CLS_LW,
        CLS_SB, CLS_SH, CLS_SW
    } instr_class_t;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_SHAMT
    } imm_fmt_t;

    typedef enum logic [1:0] {
        FU_ALU = 2'd0,
        FU_CFU = 2'd1,
        FU_LSU = 2'd2
    } fu_t;

    typedef enum logic [4:0] {
        ALU_SUB  = 5'b01_000, ALU_ADD = 5'b01_001, ALU_SLT = 5'b01_100,
        ALU_SLTU = 5'b01_110, ALU_AND = 5'b10_001, ALU_OR  = 5'b10_010,
        ALU_XOR  = 5'b10_100, ALU_SRA = 5'b11_001, ALU_SRL = 5'b11_010,
        ALU_SLL  = 5'b11_100
    } alu_op_t;

    typedef enum logic [4:0] {
        CFU_BEQ   = 5'b00_001, CFU_BGE    = 5'b00_010, CFU_BGEU = 5'b00_011,
        CFU_BLT   = 5'b00_100, CFU_BLTU   = 5'b00_101, CFU_BNE  = 5'b00_110,
        CFU_EBREAK = 5'b01_001, CFU_ECALL = 5'b01_010,
        CFU_JALI  = 5'b10_010, CFU_JALR   = 5'b10_100
    } cfu_op_t;

    typedef enum logic [1:0] {
        LSU_BYTE = 2'b01,
        LSU_HALF = 2'b10,
        LSU_WORD = 2'b11
    } lsu_width_t;

    typedef struct packed {
        logic       load;
        logic       store;
        lsu_width_t width;
        logic       is_signed;   // Sign-extend loaded data
    } lsu_uop_t;

    typedef struct packed {
        logic opra_rs1;
        logic opra_pcim;
        logic oprb_rs2;
        logic oprb_imm;
        logic oprc_rs2;
        logic oprc_pcim;
    } opr_src_t;

    // Registered output record of the decode stage
    typedef struct packed {
        logic [`FRV_REG_W-1:0] rd;     // Trap cause when trap is set
        logic [`FRV_REG_W-1:0] rs1;
        logic [`FRV_REG_W-1:0] rs2;
        logic [`FRV_XLEN-1:0]  imm;
        fu_t                   fu;
        logic [4:0]            uop;
        opr_src_t              opr_src;
        logic                  trap;
    } decode_out_t;

endpackage

// File: frv_instr_classify.sv
`timescale 1ns/10ps
`include "frv_decode_settings.svh"

module frv_instr_classify import frv_decode_pkg::*; (
    input  logic [`FRV_XLEN-1:0] instr,
    output instr_class_t         instr_class,
    output logic                 invalid
);

    opcode_t      opcode;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    instr_class_t cls;

    assign opcode = opcode_t'(instr[6:0]);   // Low bits other than 11 never match
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        cls = CLS_INVALID;
        case (opcode)
            OPC_LUI:   cls = CLS_LUI;
            OPC_AUIPC: cls = CLS_AUIPC;
            OPC_JAL:   cls = CLS_JAL;
            OPC_JALR:  if (funct3 == 3'b000) cls = CLS_JALR;
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  cls = CLS_BEQ;
                    3'b001:  cls = CLS_BNE;
                    3'b100:  cls = CLS_BLT;
                    3'b101:  cls = CLS_BGE;
                    3'b110:  cls = CLS_BLTU;
                    3'b111:  cls = CLS_BGEU;
                    default: cls = CLS_INVALID;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  cls = CLS_LB;
                    3'b001:  cls = CLS_LH;
                    3'b010:  cls = CLS_LW;
                    3'b100:  cls = CLS_LBU;
                    3'b101:  cls = CLS_LHU;
                    default: cls = CLS_INVALID;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  cls = CLS_SB;
                    3'b001:  cls = CLS_SH;
                    3'b010:  cls = CLS_SW;
                    default: cls = CLS_INVALID;
                endcase
            end
            OPC_OPIMM: begin
                case (funct3)
                    3'b000:  cls = CLS_ADDI;
                    3'b010:  cls = CLS_SLTI;
                    3'b011:  cls = CLS_SLTIU;
                    3'b100:  cls = CLS_XORI;
                    3'b110:  cls = CLS_ORI;
                    3'b111:  cls = CLS_ANDI;
                    3'b001:  if (funct7 == 7'b0000000) cls = CLS_SLLI;
                    default: begin   // Right shifts, funct7 picks the kind
                        if (funct7 == 7'b0000000)      cls = CLS_SRLI;
                        else if (funct7 == 7'b0100000) cls = CLS_SRAI;
                    end
                endcase
            end
            OPC_OP: begin
                case ({funct7, funct3})
                    10'b0000000_000: cls = CLS_ADD;
                    10'b0100000_000: cls = CLS_SUB;
                    10'b0000000_001: cls = CLS_SLL;
                    10'b0000000_010: cls = CLS_SLT;
                    10'b0000000_011: cls = CLS_SLTU;
                    10'b0000000_100: cls = CLS_XOR;
                    10'b0000000_101: cls = CLS_SRL;
                    10'b0100000_101: cls = CLS_SRA;
                    10'b0000000_110: cls = CLS_OR;
                    10'b0000000_111: cls = CLS_AND;
                    default:         cls = CLS_INVALID;
                endcase
            end
            OPC_SYSTEM: begin
                // Only ecall and ebreak, all other fields zero
                if (funct3 == 3'b000 && instr[31:21] == '0 &&
                    instr[19:15] == `FRV_REG_W'(`FRV_REG_ZERO) &&
                    instr[11:7]  == `FRV_REG_W'(`FRV_REG_ZERO)) begin
                    cls = instr[20] ? CLS_EBREAK : CLS_ECALL;
                end
            end
            default: cls = CLS_INVALID;
        endcase
    end

    assign instr_class = cls;
    assign invalid     = (cls == CLS_INVALID);

endmodule

// File: frv_imm_decode.sv
`timescale 1ns/10ps
`include "frv_decode_settings.svh"

module frv_imm_decode import frv_decode_pkg::*; (
    input  logic [`FRV_XLEN-1:0] instr,
    input  instr_class_t         instr_class,
    output logic [`FRV_XLEN-1:0] imm
);

    imm_fmt_t             fmt;
    logic [`FRV_XLEN-1:0] imm_i;
    logic [`FRV_XLEN-1:0] imm_s;
    logic [`FRV_XLEN-1:0] imm_b;
    logic [`FRV_XLEN-1:0] imm_u;
    logic [`FRV_XLEN-1:0] imm_j;
    logic [`FRV_XLEN-1:0] imm_shamt;

    // Format per class --------------------------------
    always_comb begin
        case (instr_class)
            CLS_ADDI, CLS_ANDI, CLS_ORI, CLS_XORI, CLS_SLTI, CLS_SLTIU,
            CLS_JALR, CLS_LB, CLS_LBU, CLS_LH, CLS_LHU, CLS_LW:
                fmt = IMM_I;
            CLS_SB, CLS_SH, CLS_SW:                    fmt = IMM_S;
            CLS_BEQ, CLS_BNE, CLS_BLT, CLS_BGE, CLS_BLTU, CLS_BGEU:
                fmt = IMM_B;
            CLS_LUI, CLS_AUIPC:                        fmt = IMM_U;
            CLS_JAL:                                   fmt = IMM_J;
            CLS_SLLI, CLS_SRLI, CLS_SRAI:              fmt = IMM_SHAMT;
            default:                                   fmt = IMM_NONE;
        endcase
    end

    // Standard RV32I layouts --------------------------
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_shamt = {{(`FRV_XLEN-5){1'b0}}, instr[24:20]};   // Zero-extended

    always_comb begin
        case (fmt)
            IMM_I:     imm = imm_i;
            IMM_S:     imm = imm_s;
            IMM_B:     imm = imm_b;
            IMM_U:     imm = imm_u;
            IMM_J:     imm = imm_j;
            IMM_SHAMT: imm = imm_shamt;
            default:   imm = '0;   // Reg-reg ops and system calls
        endcase
    end

endmodule

// File: frv_uop_select.sv
`timescale 1ns/10ps

module frv_uop_select import frv_decode_pkg::*; (
    input  instr_class_t instr_class,
    output fu_t          fu,
    output logic [4:0]   uop,
    output opr_src_t     opr_src
);

    logic     alu_rr;    // Register-register ALU
    logic     alu_ri;    // ALU with immediate
    logic     is_branch;
    logic     is_load;
    logic     is_store;
    logic     is_cfu;
    alu_op_t  alu_op;
    cfu_op_t  cfu_op;
    lsu_uop_t lsu_op;

    // Instruction groups ------------------------------
    assign alu_rr = instr_class inside {CLS_ADD, CLS_SUB, CLS_AND, CLS_OR, CLS_XOR,
                                        CLS_SLT, CLS_SLTU, CLS_SLL, CLS_SRL, CLS_SRA};
    assign alu_ri = instr_class inside {CLS_ADDI, CLS_ANDI, CLS_ORI, CLS_XORI, CLS_SLTI,
                                        CLS_SLTIU, CLS_SLLI, CLS_SRLI, CLS_SRAI};
    assign is_branch = instr_class inside {CLS_BEQ, CLS_BNE, CLS_BLT, CLS_BGE,
                                           CLS_BLTU, CLS_BGEU};
    assign is_load  = instr_class inside {CLS_LB, CLS_LBU, CLS_LH, CLS_LHU, CLS_LW};
    assign is_store = instr_class inside {CLS_SB, CLS_SH, CLS_SW};
    assign is_cfu   = is_branch ||
                      instr_class inside {CLS_JAL, CLS_JALR, CLS_ECALL, CLS_EBREAK};

    assign fu = is_cfu ? FU_CFU : (is_load || is_store) ? FU_LSU : FU_ALU;

    // Micro-op per unit -------------------------------
    always_comb begin
        alu_op = ALU_ADD;   // add, addi, auipc
        cfu_op = CFU_BEQ;
        lsu_op = '0;
        case (instr_class)
            CLS_SUB:             alu_op = ALU_SUB;
            CLS_AND, CLS_ANDI:   alu_op = ALU_AND;
            CLS_OR, CLS_ORI:     alu_op = ALU_OR;
            CLS_LUI:             alu_op = ALU_OR;   // Zero OR immediate
            CLS_XOR, CLS_XORI:   alu_op = ALU_XOR;
            CLS_SLT, CLS_SLTI:   alu_op = ALU_SLT;
            CLS_SLTU, CLS_SLTIU: alu_op = ALU_SLTU;
            CLS_SLL, CLS_SLLI:   alu_op = ALU_SLL;
            CLS_SRL, CLS_SRLI:   alu_op = ALU_SRL;
            CLS_SRA, CLS_SRAI:   alu_op = ALU_SRA;
            CLS_BNE:             cfu_op = CFU_BNE;
            CLS_BLT:             cfu_op = CFU_BLT;
            CLS_BGE:             cfu_op = CFU_BGE;
            CLS_BLTU:            cfu_op = CFU_BLTU;
            CLS_BGEU:            cfu_op = CFU_BGEU;
            CLS_JAL:             cfu_op = CFU_JALI;
            CLS_JALR:            cfu_op = CFU_JALR;
            CLS_ECALL:           cfu_op = CFU_ECALL;
            CLS_EBREAK:          cfu_op = CFU_EBREAK;
            CLS_LB:  lsu_op = '{load: 1'b1, store: 1'b0, width: LSU_BYTE, is_signed: 1'b1};
            CLS_LBU: lsu_op = '{load: 1'b1, store: 1'b0, width: LSU_BYTE, is_signed: 1'b0};
            CLS_LH:  lsu_op = '{load: 1'b1, store: 1'b0, width: LSU_HALF, is_signed: 1'b1};
            CLS_LHU: lsu_op = '{load: 1'b1, store: 1'b0, width: LSU_HALF, is_signed: 1'b0};
            CLS_LW:  lsu_op = '{load: 1'b1, store: 1'b0, width: LSU_WORD, is_signed: 1'b0};
            CLS_SB:  lsu_op = '{load: 1'b0, store: 1'b1, width: LSU_BYTE, is_signed: 1'b0};
            CLS_SH:  lsu_op = '{load: 1'b0, store: 1'b1, width: LSU_HALF, is_signed: 1'b0};
            CLS_SW:  lsu_op = '{load: 1'b0, store: 1'b1, width: LSU_WORD, is_signed: 1'b0};
            default: ;
        endcase
    end

    always_comb begin
        case (fu)
            FU_CFU:  uop = cfu_op;
            FU_LSU:  uop = lsu_op;
            default: uop = alu_op;
        endcase
    end

    // Operand sources ---------------------------------
    assign opr_src.opra_rs1  = alu_rr || alu_ri || is_branch || is_load || is_store ||
                               instr_class == CLS_JALR;
    assign opr_src.opra_pcim = instr_class == CLS_AUIPC;
    assign opr_src.oprb_rs2  = alu_rr || is_branch;
    assign opr_src.oprb_imm  = alu_ri || is_load || is_store ||
                               instr_class inside {CLS_LUI, CLS_JALR};
    assign opr_src.oprc_rs2  = is_store;                           // Store data
    assign opr_src.oprc_pcim = is_branch || instr_class == CLS_JAL; // Target address

endmodule

// File: frv_decode_result.sv
`timescale 1ns/10ps
`include "frv_decode_settings.svh"

module frv_decode_result import frv_decode_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 d_valid,
    input  logic                 d_error,
    input  logic [`FRV_XLEN-1:0] instr,
    input  logic                 invalid,
    input  logic [`FRV_XLEN-1:0] imm,
    input  fu_t                  fu,
    input  logic [4:0]           uop,
    input  opr_src_t             opr_src,
    output logic                 p_valid,
    output decode_out_t          p_out
);

    logic                  trap;
    logic [`FRV_REG_W-1:0] cause;
    decode_out_t           rec;

    // Illegal instruction wins over the fetch fault
    assign trap  = d_error || invalid;
    assign cause = invalid ? `FRV_REG_W'(`FRV_TRAP_IOPCODE) : `FRV_REG_W'(`FRV_TRAP_IACCESS);

    always_comb begin
        rec.rd      = trap ? cause : instr[11:7];
        rec.rs1     = instr[19:15];
        rec.rs2     = instr[24:20];
        rec.imm     = imm;
        rec.fu      = fu;
        rec.uop     = uop;
        rec.opr_src = opr_src;
        rec.trap    = trap;
    end

    // Single pipeline register --------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            p_valid    <= 1'b0;
            p_out.trap <= 1'b0;
        end else begin
            p_valid <= d_valid;
            if (d_valid) p_out <= rec;   // Holds between valid words
        end
    end

endmodule

// File: frv_pipeline_decode.sv
`timescale 1ns/10ps
`include "frv_decode_settings.svh"

module frv_pipeline_decode import frv_decode_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 d_valid,   // Fetched word present
    input  logic [`FRV_XLEN-1:0] d_data,
    input  logic                 d_error,   // Fetch fault for d_data
    output logic                 p_valid,
    output decode_out_t          p_out
);

    instr_class_t         instr_class;
    logic                 invalid;
    logic [`FRV_XLEN-1:0] imm;
    fu_t                  fu;
    logic [4:0]           uop;
    opr_src_t             opr_src;

    frv_instr_classify u_classify (
        .instr       (d_data),
        .instr_class (instr_class),
        .invalid     (invalid)
    );

    frv_imm_decode u_imm (
        .instr       (d_data),
        .instr_class (instr_class),
        .imm         (imm)
    );

    frv_uop_select u_uop (
        .instr_class (instr_class),
        .fu          (fu),
        .uop         (uop),
        .opr_src     (opr_src)
    );

    frv_decode_result u_result (
        .clk     (clk),
        .rst_n   (rst_n),
        .d_valid (d_valid),
        .d_error (d_error),
        .instr   (d_data),
        .invalid (invalid),
        .imm     (imm),
        .fu      (fu),
        .uop     (uop),
        .opr_src (opr_src),
        .p_valid (p_valid),
        .p_out   (p_out)
    );

endmodule

// File: frv_decode_assertions.sv
`timescale 1ns/10ps
`include "frv_decode_settings.svh"

module frv_decode_assertions import frv_decode_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input logic        d_valid,
    input logic        p_valid,
    input decode_out_t p_out
);

    int fail_cnt = 0;   // Failed checks so far

    a_valid_delay: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> p_valid == $past(d_valid))
        else begin
            $error("p_valid does not follow d_valid by one cycle");
            fail_cnt++;
        end

    // Register cleared while reset is held
    a_reset_idle: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) |-> !p_valid)
        else begin
            $error("p_valid high during reset");
            fail_cnt++;
        end

    a_trap_cause: assert property (@(posedge clk) disable iff (!rst_n)
        p_out.trap |-> p_out.rd inside {`FRV_TRAP_IACCESS, `FRV_TRAP_IOPCODE})
        else begin
            $error("trap without a known cause in rd");
            fail_cnt++;
        end

    a_unit_known: assert property (@(posedge clk) disable iff (!rst_n)
        (p_valid && !p_out.trap) |-> p_out.fu inside {FU_ALU, FU_CFU, FU_LSU})
        else begin
            $error("fu outside the three functional units");
            fail_cnt++;
        end

endmodule

bind frv_pipeline_decode frv_decode_assertions u_assertions (
    .clk     (clk),
    .rst_n   (rst_n),
    .d_valid (d_valid),
    .p_valid (p_valid),
    .p_out   (p_out)
);

// File: tb_frv_pipeline_decode.sv
`timescale 1ns/10ps
`include "frv_decode_settings.svh"

module tb_frv_pipeline_decode import frv_decode_pkg::*; ();

    localparam int REPS    = 4;    // Passes over each instruction group
    localparam int N_INV   = 8;
    localparam int N_BURST = 16;

    // Reset and settle, ALU, CFU, LSU, invalid and error words, burst, drain
    localparam int STIM_CYCLES = 5 + (21 * REPS + 1) + (8 * REPS + 3) + (8 * REPS + 1) +
                                 (N_INV + 4 + 2 * REPS + 1) + (N_BURST + N_BURST / 2) + 4;
    localparam int TIMEOUT = 2 * STIM_CYCLES + 20;

    // {funct7, funct3} of the register and immediate ALU forms
    localparam logic [99:0] R_OPS = {10'b0000000_000, 10'b0100000_000, 10'b0000000_001,
                                     10'b0000000_010, 10'b0000000_011, 10'b0000000_100,
                                     10'b0000000_101, 10'b0100000_101, 10'b0000000_110,
                                     10'b0000000_111};
    localparam logic [89:0] I_OPS = {10'b0000000_000, 10'b0000000_010, 10'b0000000_011,
                                     10'b0000000_100, 10'b0000000_110, 10'b0000000_111,
                                     10'b0000000_001, 10'b0000000_101, 10'b0100000_101};
    localparam logic [17:0] B_F3  = {3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    localparam logic [14:0] LD_F3 = {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
    localparam logic [8:0]  ST_F3 = {3'b000, 3'b001, 3'b010};

    logic        clk = 1'b0;
    logic        rst_n;
    logic        d_valid;
    logic [31:0] d_data;
    logic        d_error;
    logic        p_valid;
    decode_out_t p_out;

    integer      seed;
    int          cycle_cnt    = 0;
    int          mismatches   = 0;
    int          proto_errors = 0;
    decode_out_t exp_q[$];
    int          cyc_q[$];   // Cycle count at the drive edge

    always #4 clk = ~clk;

    frv_pipeline_decode DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .d_valid (d_valid),
        .d_data  (d_data),
        .d_error (d_error),
        .p_valid (p_valid),
        .p_out   (p_out)
    );

    // Reference decode ----------------------------------
    function automatic alu_op_t alu_op_for(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic cfu_op_t branch_op_for(input logic [2:0] f3);
        case (f3)
            3'b000:  return CFU_BEQ;
            3'b001:  return CFU_BNE;
            3'b100:  return CFU_BLT;
            3'b101:  return CFU_BGE;
            3'b110:  return CFU_BLTU;
            default: return CFU_BGEU;
        endcase
    endfunction

    function automatic lsu_width_t lsu_width_for(input logic [1:0] sz);
        case (sz)
            2'b00:   return LSU_BYTE;
            2'b01:   return LSU_HALF;
            default: return LSU_WORD;
        endcase
    endfunction

    function automatic decode_out_t ref_decode(input logic [31:0] w, input logic err);
        decode_out_t r;
        lsu_uop_t    lu;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        ok;
        logic [31:0] imm_i;
        f3    = w[14:12];
        f7    = w[31:25];
        imm_i = $signed(w) >>> 20;
        r     = '0;
        lu    = '0;
        ok    = 1'b1;
        r.rd  = w[11:7];
        r.rs1 = w[19:15];
        r.rs2 = w[24:20];
        // Operand flags as {opra_rs1, opra_pcim, oprb_rs2, oprb_imm, oprc_rs2, oprc_pcim}
        case (w[6:0])
            7'b0110011: begin   // Register-register ALU
                ok        = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
                r.uop     = alu_op_for(f3, w[30]);
                r.opr_src = 6'b101000;
            end
            7'b0010011: begin   // ALU immediate and shifts
                ok        = (f3 != 3'b001 && f3 != 3'b101) || f7 == 7'h00 ||
                            (f3 == 3'b101 && f7 == 7'h20);
                r.uop     = alu_op_for(f3, f3 == 3'b101 && w[30]);
                r.imm     = (f3 == 3'b001 || f3 == 3'b101) ? {27'd0, w[24:20]} : imm_i;
                r.opr_src = 6'b100100;
            end
            7'b0110111: begin   // lui
                r.imm     = w & 32'hffff_f000;
                r.uop     = ALU_OR;
                r.opr_src = 6'b000100;
            end
            7'b0010111: begin   // auipc
                r.imm     = w & 32'hffff_f000;
                r.uop     = ALU_ADD;
                r.opr_src = 6'b010000;
            end
            7'b1101111: begin   // jal
                r.fu      = FU_CFU;
                r.imm     = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
                r.uop     = CFU_JALI;
                r.opr_src = 6'b000001;
            end
            7'b1100111: begin   // jalr
                ok        = f3 == 3'b000;
                r.fu      = FU_CFU;
                r.imm     = imm_i;
                r.uop     = CFU_JALR;
                r.opr_src = 6'b100100;
            end
            7'b1100011: begin
                ok        = f3[2:1] != 2'b01;
                r.fu      = FU_CFU;
                r.imm     = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
                r.uop     = branch_op_for(f3);
                r.opr_src = 6'b101001;
            end
            7'b0000011: begin
                ok           = f3[1:0] != 2'b11 && !(f3[2] && f3[1]);
                lu.load      = 1'b1;
                lu.width     = lsu_width_for(f3[1:0]);
                lu.is_signed = !f3[2] && f3[1:0] != 2'b10;   // lb and lh only
                r.fu         = FU_LSU;
                r.imm        = imm_i;
                r.uop        = lu;
                r.opr_src    = 6'b100100;
            end
            7'b0100011: begin
                ok        = !f3[2] && f3[1:0] != 2'b11;
                lu.store  = 1'b1;
                lu.width  = lsu_width_for(f3[1:0]);
                r.fu      = FU_LSU;
                r.imm     = {imm_i[31:5], w[11:7]};
                r.uop     = lu;
                r.opr_src = 6'b100110;
            end
            7'b1110011: begin   // ecall and ebreak only
                ok    = w[31:21] == '0 && w[19:7] == '0;
                r.fu  = FU_CFU;
                r.uop = w[20] ? CFU_EBREAK : CFU_ECALL;
            end
            default: ok = 1'b0;
        endcase
        if (err || !ok) begin
            r.trap = 1'b1;
            r.rd   = ok ? `FRV_REG_W'(`FRV_TRAP_IACCESS) : `FRV_REG_W'(`FRV_TRAP_IOPCODE);
        end
        return r;
    endfunction

    // Drive and compare ---------------------------------
    task automatic drive_word(input logic [31:0] w, input logic err);
        @(posedge clk);
        d_valid <= 1'b1;
        d_data  <= w;
        d_error <= err;
        exp_q.push_back(ref_decode(w, err));
        cyc_q.push_back(cycle_cnt);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        d_valid <= 1'b0;
        d_data  <= $random(seed);   // Ignored by the stage
        d_error <= 1'b0;
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%08h expected 0x%08h", name, got, exp);
            mismatches++;
        end
    endtask

    always @(negedge clk) begin : compare
        decode_out_t exp;
        int          cyc;
        if (p_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Result appeared at %0t with no word outstanding", $time);
                proto_errors++;
            end else begin
                exp = exp_q.pop_front();
                cyc = cyc_q.pop_front();
                if (cycle_cnt != cyc + 2) begin
                    $display("Result at %0t did not arrive one cycle after its word", $time);
                    proto_errors++;
                end
                check_field("trap", p_out.trap, exp.trap);
                check_field("rd", p_out.rd, exp.rd);
                if (!exp.trap) begin   // Other fields are don't-care on a trap
                    check_field("rs1", p_out.rs1, exp.rs1);
                    check_field("rs2", p_out.rs2, exp.rs2);
                    check_field("imm", p_out.imm, exp.imm);
                    check_field("fu", p_out.fu, exp.fu);
                    check_field("uop", p_out.uop, exp.uop);
                    check_field("opr_src", p_out.opr_src, exp.opr_src);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Run did not finish within %0d cycles", TIMEOUT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Stimulus ------------------------------------------
    initial begin
        logic [31:0] w;
        logic [9:0]  op;
        int          total;
        rst_n   = 1'b0;
        d_valid = 1'b0;
        d_data  = '0;
        d_error = 1'b0;
        seed    = 72951;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        idle_cycle();
        idle_cycle();

        for (int k = 0; k < REPS; k++) begin
            for (int i = 0; i < 10; i++) begin
                w  = $random(seed);
                op = R_OPS[i*10 +: 10];
                drive_word({op[9:3], w[24:15], op[2:0], w[11:7], 7'b0110011}, 1'b0);
            end
            for (int i = 0; i < 9; i++) begin
                w  = $random(seed);
                op = I_OPS[i*10 +: 10];
                w[14:12] = op[2:0];
                w[6:0]   = 7'b0010011;
                if (op[2:0] == 3'b001 || op[2:0] == 3'b101) w[31:25] = op[9:3];
                drive_word(w, 1'b0);
            end
            w = $random(seed);
            drive_word({w[31:7], 7'b0110111}, 1'b0);   // lui
            w = $random(seed);
            drive_word({w[31:7], 7'b0010111}, 1'b0);   // auipc
        end
        idle_cycle();

        // Control flow with negative offsets on even passes
        for (int k = 0; k < REPS; k++) begin
            for (int i = 0; i < 6; i++) begin
                w = $random(seed);
                if (k % 2 == 0) w[31] = 1'b1;
                drive_word({w[31:15], B_F3[i*3 +: 3], w[11:7], 7'b1100011}, 1'b0);
            end
            w = $random(seed);
            if (k % 2 == 0) w[31] = 1'b1;
            drive_word({w[31:7], 7'b1101111}, 1'b0);
            w = $random(seed);
            if (k % 2 == 0) w[31] = 1'b1;
            drive_word({w[31:15], 3'b000, w[11:7], 7'b1100111}, 1'b0);
        end
        drive_word(32'h0000_0073, 1'b0);   // ecall
        drive_word(32'h0010_0073, 1'b0);   // ebreak
        idle_cycle();

        for (int k = 0; k < REPS; k++) begin
            for (int i = 0; i < 5; i++) begin
                w = $random(seed);
                drive_word({w[31:15], LD_F3[i*3 +: 3], w[11:7], 7'b0000011}, 1'b0);
            end
            for (int i = 0; i < 3; i++) begin
                w = $random(seed);
                drive_word({w[31:15], ST_F3[i*3 +: 3], w[11:7], 7'b0100011}, 1'b0);
            end
        end
        idle_cycle();

        // Illegal words and fetch faults
        for (int i = 0; i < N_INV; i++) begin
            w    = $random(seed);
            w[0] = 1'b0;
            drive_word(w, 1'b0);
        end
        drive_word(32'h0000_100f, 1'b0);   // fence.i
        drive_word(32'h0200_0033, 1'b0);   // mul
        drive_word(32'h3020_0073, 1'b0);   // mret
        drive_word(32'h0000_2073, 1'b0);   // csrrs
        for (int k = 0; k < REPS; k++) begin
            w = $random(seed);
            drive_word({w[31:15], 3'b000, w[11:7], 7'b0010011}, 1'b1);
            w    = $random(seed);
            w[0] = 1'b0;
            drive_word(w, 1'b1);
        end
        idle_cycle();

        // Back-to-back pairs separated by idle cycles
        for (int i = 0; i < N_BURST; i++) begin
            w = $random(seed);
            case (i % 4)
                0:       w[6:0] = 7'b0110111;
                1:       w[6:0] = 7'b1101111;
                2:       w[14:0] = {3'b000, w[11:7], 7'b0010011};
                default: ;   // Raw random word
            endcase
            drive_word(w, 1'b0);
            if (i % 2 == 1) idle_cycle();
        end
        idle_cycle();

        for (int i = 0; i < 4 && exp_q.size() != 0; i++) @(posedge clk);
        @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d decoded words never came out of the stage", exp_q.size());
            proto_errors += exp_q.size();
        end
        total = mismatches + proto_errors + DUT.u_assertions.fail_cnt;
        $display("Summary: %0d value mismatches, %0d protocol errors, %0d assertion failures",
                 mismatches, proto_errors, DUT.u_assertions.fail_cnt);
        if (total == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+.
frv_decode_pkg.sv
frv_instr_classify.sv
frv_imm_decode.sv
frv_uop_select.sv
frv_decode_result.sv
frv_pipeline_decode.sv
frv_decode_assertions.sv
tb_frv_pipeline_decode.sv

// File: Bender.yml
package:
  name: frv_pipeline_decode

export_include_dirs:
  - .

sources:
  - frv_decode_pkg.sv
  - frv_instr_classify.sv
  - frv_imm_decode.sv
  - frv_uop_select.sv
  - frv_decode_result.sv
  - frv_pipeline_decode.sv
  - target: test
    files:
      - frv_decode_assertions.sv
      - tb_frv_pipeline_decode.sv
